//--- Makefile
VERILATOR ?= verilator
TOP       ?= segre_hazard_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= Everything OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- design/segre_bypass_controller.sv
module segre_bypass_controller import segre_pkg::*; (
    input  logic         clk_i,
    input  logic         arst_n_i,

    // Instruction in decode
    input  decode_t      dec_i,
    input  pipeline_e    dec_pipeline_i,

    // Instruction sitting in the ID to pipeline register
    input  issue_t       id_i,

    // Destinations in flight
    input  bypass_data_t pipeline_data_i,

    output bypass_e      bypass_a_o,
    output bypass_e      bypass_b_o,
    output logic         war_dependence_o,
    output logic         waw_dependence_o
);

    logic use_a;
    logic use_b;
    logic is_store;
    logic id_fwd;
    logic id_hit_a;
    logic id_hit_b;
    logic dep_a;
    logic dep_b;

    // Operand usage by opcode
    assign use_a = (dec_i.src_a != '0) &&
                   (dec_i.opcode != OPCODE_JAL) &&
                   (dec_i.opcode != OPCODE_LUI) &&
                   (dec_i.opcode != OPCODE_AUIPC);
    assign use_b = (dec_i.src_b != '0) &&
                   (dec_i.opcode == OPCODE_BRANCH ||
                    dec_i.opcode == OPCODE_STORE  ||
                    dec_i.opcode == OPCODE_OP);
    assign is_store = (dec_i.opcode == OPCODE_STORE);

    // Single-cycle EX producers can forward straight out of the EX stage
    assign id_fwd = (id_i.pipeline == EX_PIPELINE) &&
                    (id_i.opcode == OPCODE_OP    || id_i.opcode == OPCODE_OP_IMM ||
                     id_i.opcode == OPCODE_LUI   || id_i.opcode == OPCODE_AUIPC);

    assign id_hit_a = id_i.valid && (dec_i.src_a == id_i.dest);
    assign id_hit_b = id_i.valid && (dec_i.src_b == id_i.dest);

    assign war_dependence_o = dep_a | dep_b;

    always_comb begin : src_a_select
        bypass_a_o = NO_BYPASS;
        dep_a      = 1'b0;
        if (use_a) begin
            if (id_hit_a) begin
                if (id_fwd) bypass_a_o = BY_EX_PIPE;
                else        dep_a      = 1'b1;
            end
            else if (dec_i.src_a == pipeline_data_i.ex_wreg)   bypass_a_o = BY_EX_ID;
            else if (dec_i.src_a == pipeline_data_i.mem_wreg)  bypass_a_o = BY_MEM_ID;
            else if (dec_i.src_a == pipeline_data_i.rvm5_wreg) bypass_a_o = BY_RVM5_ID;
            else if (dec_i.src_a == pipeline_data_i.rvm4_wreg) bypass_a_o = BY_RVM5_PIPE;
            else if (dec_i.src_a == pipeline_data_i.tl_wreg)   bypass_a_o = BY_MEM_PIPE;
            else if (dec_i.src_a == pipeline_data_i.alu_mem_wreg ||
                     dec_i.src_a == pipeline_data_i.rvm1_wreg    ||
                     dec_i.src_a == pipeline_data_i.rvm2_wreg    ||
                     dec_i.src_a == pipeline_data_i.rvm3_wreg) begin
                dep_a = 1'b1;
            end
        end
    end

    always_comb begin : src_b_select
        bypass_b_o = NO_BYPASS;
        dep_b      = 1'b0;
        if (use_b) begin
            if (id_hit_b) begin
                // Store data is only needed late, so a slow producer is caught downstream
                if (id_fwd)         bypass_b_o = BY_EX_PIPE;
                else if (!is_store) dep_b      = 1'b1;
            end
            else if (dec_i.src_b == pipeline_data_i.ex_wreg)   bypass_b_o = BY_EX_ID;
            else if (dec_i.src_b == pipeline_data_i.mem_wreg)  bypass_b_o = BY_MEM_ID;
            else if (dec_i.src_b == pipeline_data_i.rvm5_wreg) bypass_b_o = BY_RVM5_ID;
            else if (dec_i.src_b == pipeline_data_i.rvm4_wreg) bypass_b_o = BY_RVM5_PIPE;
            else if (dec_i.src_b == pipeline_data_i.tl_wreg)   bypass_b_o = BY_MEM_PIPE;
            else if (dec_i.src_b == pipeline_data_i.alu_mem_wreg) begin
                if (is_store) bypass_b_o = BY_MEM_TL;
                else          dep_b      = 1'b1;
            end
            else if (dec_i.src_b == pipeline_data_i.rvm3_wreg && is_store) begin
                bypass_b_o = BY_RVM5_TL;
            end
            else if (dec_i.src_b == pipeline_data_i.rvm1_wreg ||
                     dec_i.src_b == pipeline_data_i.rvm2_wreg ||
                     dec_i.src_b == pipeline_data_i.rvm3_wreg) begin
                dep_b = 1'b1;
            end
        end
    end

    // A shorter pipeline must not retire its write before an older longer one
    always_comb begin : waw_detect
        waw_dependence_o = 1'b0;
        if (dec_i.dest != '0) begin
            if (dec_pipeline_i == EX_PIPELINE) begin
                if (id_i.valid && dec_i.dest == id_i.dest &&
                    id_i.pipeline != EX_PIPELINE) begin
                    waw_dependence_o = 1'b1;
                end
                if (dec_i.dest == pipeline_data_i.alu_mem_wreg ||
                    dec_i.dest == pipeline_data_i.rvm1_wreg    ||
                    dec_i.dest == pipeline_data_i.rvm2_wreg    ||
                    dec_i.dest == pipeline_data_i.rvm3_wreg) begin
                    waw_dependence_o = 1'b1;
                end
            end
            else if (dec_pipeline_i == MEM_PIPELINE) begin
                if (id_i.valid && dec_i.dest == id_i.dest &&
                    id_i.pipeline == RVM_PIPELINE) begin
                    waw_dependence_o = 1'b1;
                end
                if (dec_i.dest == pipeline_data_i.rvm1_wreg) begin
                    waw_dependence_o = 1'b1;
                end
            end
        end
    end

    // A stalled operand never also selects a forwarding path
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (dep_a |-> bypass_a_o == NO_BYPASS) and (dep_b |-> bypass_b_o == NO_BYPASS));

    // x0 is hardwired, nothing may be forwarded into it
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (dec_i.src_a == '0 |-> bypass_a_o == NO_BYPASS) and
        (dec_i.src_b == '0 |-> bypass_b_o == NO_BYPASS));

endmodule : segre_bypass_controller

//--- design/segre_hazard_unit.sv
module segre_hazard_unit import segre_pkg::*; (
    input  logic    clk_i,
    input  logic    arst_n_i,

    // Decoder side
    input  logic    dec_valid_i,
    input  decode_t dec_i,

    output logic    stall_o,
    output logic    issue_o,
    output bypass_e bypass_a_o,
    output bypass_e bypass_b_o
);

    pipeline_e    dec_pipeline;
    issue_t       id_q;
    bypass_data_t pipe_data;
    logic         war_dep;
    logic         waw_dep;

    segre_issue_control issue_control (
        .clk_i            (clk_i),
        .arst_n_i         (arst_n_i),
        .dec_valid_i      (dec_valid_i),
        .dec_i            (dec_i),
        .war_dependence_i (war_dep),
        .waw_dependence_i (waw_dep),
        .dec_pipeline_o   (dec_pipeline),
        .id_o             (id_q),
        .stall_o          (stall_o),
        .issue_o          (issue_o)
    );

    segre_wreg_tracker wreg_tracker (
        .clk_i           (clk_i),
        .arst_n_i        (arst_n_i),
        .id_i            (id_q),
        .pipeline_data_o (pipe_data)
    );

    segre_bypass_controller bypass_controller (
        .clk_i            (clk_i),
        .arst_n_i         (arst_n_i),
        .dec_i            (dec_i),
        .dec_pipeline_i   (dec_pipeline),
        .id_i             (id_q),
        .pipeline_data_i  (pipe_data),
        .bypass_a_o       (bypass_a_o),
        .bypass_b_o       (bypass_b_o),
        .war_dependence_o (war_dep),
        .waw_dependence_o (waw_dep)
    );

endmodule : segre_hazard_unit

//--- design/segre_issue_control.sv
module segre_issue_control import segre_pkg::*; (
    input  logic      clk_i,
    input  logic      arst_n_i,

    // Decoded instruction
    input  logic      dec_valid_i,
    input  decode_t   dec_i,

    // Hazards reported by the bypass controller
    input  logic      war_dependence_i,
    input  logic      waw_dependence_i,

    output pipeline_e dec_pipeline_o,
    output issue_t    id_o,
    output logic      stall_o,
    output logic      issue_o
);

    pipeline_e dec_pipeline;
    issue_t    id_d;
    issue_t    id_q;

    // Pick the back-end pipeline from the opcode
    always_comb begin : pipeline_select
        case (dec_i.opcode)
            OPCODE_OP: begin
                if (dec_i.is_muldiv) dec_pipeline = RVM_PIPELINE;
                else                 dec_pipeline = EX_PIPELINE;
            end
            OPCODE_LOAD,
            OPCODE_STORE: dec_pipeline = MEM_PIPELINE;
            default:      dec_pipeline = EX_PIPELINE;
        endcase
    end

    assign dec_pipeline_o = dec_pipeline;

    // Hold the instruction in decode while any hazard is open
    assign stall_o = dec_valid_i & (war_dependence_i | waw_dependence_i);
    assign issue_o = dec_valid_i & ~stall_o;

    // Bubble when nothing is issued
    always_comb begin : id_next
        id_d = '0;
        if (issue_o) begin
            id_d.valid    = 1'b1;
            id_d.dest     = dec_i.dest;
            id_d.opcode   = dec_i.opcode;
            id_d.pipeline = dec_pipeline;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin : id_reg
        if (!arst_n_i) begin
            id_q <= '0;
        end
        else begin
            id_q <= id_d;
        end
    end

    assign id_o = id_q;

    // Stall and issue are exclusive
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !(stall_o && issue_o));

endmodule : segre_issue_control

//--- design/segre_pkg.sv
`include "segre_cfg.svh"

package segre_pkg;

    // Major opcodes seen by the hazard logic, real RV32 encodings
    typedef enum logic [6:0] {
        OPCODE_LOAD   = 7'b0000011,
        OPCODE_OP_IMM = 7'b0010011,
        OPCODE_AUIPC  = 7'b0010111,
        OPCODE_STORE  = 7'b0100011,
        OPCODE_OP     = 7'b0110011,
        OPCODE_LUI    = 7'b0110111,
        OPCODE_BRANCH = 7'b1100011,
        OPCODE_JAL    = 7'b1101111
    } opcode_e;

    // Back-end pipeline an instruction is sent to
    typedef enum logic [1:0] {
        EX_PIPELINE,
        MEM_PIPELINE,
        RVM_PIPELINE
    } pipeline_e;

    // Source of an operand for the instruction in decode
    typedef enum logic [3:0] {
        NO_BYPASS,
        BY_EX_PIPE,
        BY_EX_ID,
        BY_MEM_ID,
        BY_MEM_PIPE,
        BY_MEM_TL,
        BY_RVM5_ID,
        BY_RVM5_PIPE,
        BY_RVM5_TL
    } bypass_e;

    // Destination register held in each back-end stage
    // Zero means the stage carries no write
    typedef struct packed {
        logic [`REG_SIZE-1:0] ex_wreg;
        logic [`REG_SIZE-1:0] alu_mem_wreg;
        logic [`REG_SIZE-1:0] tl_wreg;
        logic [`REG_SIZE-1:0] mem_wreg;
        logic [`REG_SIZE-1:0] rvm1_wreg;
        logic [`REG_SIZE-1:0] rvm2_wreg;
        logic [`REG_SIZE-1:0] rvm3_wreg;
        logic [`REG_SIZE-1:0] rvm4_wreg;
        logic [`REG_SIZE-1:0] rvm5_wreg;
    } bypass_data_t;

    // Instruction fields coming out of the decoder
    typedef struct packed {
        logic [`REG_SIZE-1:0] src_a;
        logic [`REG_SIZE-1:0] src_b;
        logic [`REG_SIZE-1:0] dest;
        opcode_e              opcode;
        logic                 is_muldiv;
    } decode_t;

    // ID to pipeline register contents
    typedef struct packed {
        logic                 valid;
        logic [`REG_SIZE-1:0] dest;
        opcode_e              opcode;
        pipeline_e            pipeline;
    } issue_t;

endpackage : segre_pkg

//--- design/segre_wreg_tracker.sv
`include "segre_cfg.svh"

module segre_wreg_tracker import segre_pkg::*; (
    input  logic         clk_i,
    input  logic         arst_n_i,

    // Entry leaving the ID to pipeline register
    input  issue_t       id_i,

    output bypass_data_t pipeline_data_o
);

    logic [`REG_SIZE-1:0] ex_wreg;
    logic [`REG_SIZE-1:0] mem_chain [`MEM_STAGES];
    logic [`REG_SIZE-1:0] rvm_chain [`RVM_STAGES];
    logic [`REG_SIZE-1:0] ex_in;
    logic [`REG_SIZE-1:0] mem_in;
    logic [`REG_SIZE-1:0] rvm_in;

    // Steer the ID destination into the first stage of its pipeline
    always_comb begin : entry_steer
        ex_in  = '0;
        mem_in = '0;
        rvm_in = '0;
        if (id_i.valid) begin
            case (id_i.pipeline)
                EX_PIPELINE:  ex_in  = id_i.dest;
                MEM_PIPELINE: mem_in = id_i.dest;
                RVM_PIPELINE: rvm_in = id_i.dest;
                default:      ex_in  = '0;
            endcase
        end
    end

    // Shift every cycle, the back end never stalls
    always_ff @(posedge clk_i or negedge arst_n_i) begin : stage_shift
        if (!arst_n_i) begin
            ex_wreg <= '0;
            for (int i = 0; i < `MEM_STAGES; i++) begin
                mem_chain[i] <= '0;
            end
            for (int j = 0; j < `RVM_STAGES; j++) begin
                rvm_chain[j] <= '0;
            end
        end
        else begin
            ex_wreg      <= ex_in;
            mem_chain[0] <= mem_in;
            for (int i = 1; i < `MEM_STAGES; i++) begin
                mem_chain[i] <= mem_chain[i-1];
            end
            rvm_chain[0] <= rvm_in;
            for (int j = 1; j < `RVM_STAGES; j++) begin
                rvm_chain[j] <= rvm_chain[j-1];
            end
        end
    end

    // Stage view for the bypass logic
    assign pipeline_data_o.ex_wreg      = ex_wreg;
    assign pipeline_data_o.alu_mem_wreg = mem_chain[0];
    assign pipeline_data_o.tl_wreg      = mem_chain[1];
    assign pipeline_data_o.mem_wreg     = mem_chain[2];
    assign pipeline_data_o.rvm1_wreg    = rvm_chain[0];
    assign pipeline_data_o.rvm2_wreg    = rvm_chain[1];
    assign pipeline_data_o.rvm3_wreg    = rvm_chain[2];
    assign pipeline_data_o.rvm4_wreg    = rvm_chain[3];
    assign pipeline_data_o.rvm5_wreg    = rvm_chain[4];

    // Single issue means at most one pipeline entry stage is filled per cycle
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $onehot0({ex_wreg != '0, mem_chain[0] != '0, rvm_chain[0] != '0}));

endmodule : segre_wreg_tracker

//--- segre_cfg.svh
`ifndef SEGRE_CFG_SVH
`define SEGRE_CFG_SVH

// Width of a register index (x0..x31)
`define REG_SIZE 5

// Depth of the multiply/divide pipeline
`define RVM_STAGES 5

// Depth of the memory pipeline
// Stages are address, tag lookup and memory access
`define MEM_STAGES 3

`endif

//--- verif/segre_hazard_tb.sv
`include "segre_cfg.svh"

module segre_hazard_tb import segre_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    logic    clk;
    logic    arst_n;
    logic    dec_valid;
    decode_t dec;
    logic    stall;
    logic    issue;
    bypass_e bypass_a;
    bypass_e bypass_b;

    int checks   = 0;
    int errors   = 0;
    int timeouts = 0;

    // Distinct nonzero registers for the current test
    logic [`REG_SIZE-1:0] r [6];

    segre_tb_clk clk_gen (
        .clk_o    (clk),
        .arst_n_o (arst_n)
    );

    segre_hazard_unit segre_hazard_unit_inst (
        .clk_i       (clk),
        .arst_n_i    (arst_n),
        .dec_valid_i (dec_valid),
        .dec_i       (dec),
        .stall_o     (stall),
        .issue_o     (issue),
        .bypass_a_o  (bypass_a),
        .bypass_b_o  (bypass_b)
    );

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0d ns: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic expect_outputs(input logic exp_stall, input logic exp_issue,
                                  input bypass_e exp_a, input bypass_e exp_b);
        check("stall_o", 32'(stall), 32'(exp_stall));
        check("issue_o", 32'(issue), 32'(exp_issue));
        check("bypass_a_o", 32'(bypass_a), 32'(exp_a));
        check("bypass_b_o", 32'(bypass_b), 32'(exp_b));
    endtask

    // Inputs change 1 ns after the rising edge
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic drive_instr(input logic [`REG_SIZE-1:0] src_a, input logic [`REG_SIZE-1:0] src_b,
                               input logic [`REG_SIZE-1:0] dest, input opcode_e op,
                               input logic muldiv);
        dec_valid     = 1'b1;
        dec.src_a     = src_a;
        dec.src_b     = src_b;
        dec.dest      = dest;
        dec.opcode    = op;
        dec.is_muldiv = muldiv;
    endtask

    task automatic drive_idle();
        dec_valid = 1'b0;
        dec       = '0;
    endtask

    // Let every stage drain before the next test
    task automatic flush_pipes();
        drive_idle();
        repeat (`RVM_STAGES + 2) tick();
    endtask

    task automatic pick_distinct_regs();
        int unsigned pick;
        logic        clash;
        for (int i = 0; i < 6; i++) begin
            do begin
                pick  = $urandom_range(31, 1);
                clash = 1'b0;
                for (int j = 0; j < i; j++) begin
                    if (r[j] == pick[`REG_SIZE-1:0]) begin
                        clash = 1'b1;
                    end
                end
            end while (clash);
            r[i] = pick[`REG_SIZE-1:0];
        end
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (!arst_n && cycles < 20) begin
            @(posedge clk);
            cycles++;
        end
        if (!arst_n) begin
            timeouts++;
            $display("Timeout: reset was never released");
        end
        tick();
    endtask

    // Count stall cycles until the held instruction issues, sampled at the falling edge
    task automatic wait_issue(input int limit, output int stalls);
        stalls = 0;
        @(negedge clk);
        while (stall && stalls < limit) begin
            check("issue_o", 32'(issue), 32'd0);
            stalls++;
            tick();
            @(negedge clk);
        end
        if (stall) begin
            timeouts++;
            $display("Timeout: instruction still stalled after %0d cycles", limit);
        end
    endtask

    task automatic test_reset_idle();
        @(negedge clk);
        expect_outputs(1'b0, 1'b0, NO_BYPASS, NO_BYPASS);
        wait_reset_release();
        @(negedge clk);
        expect_outputs(1'b0, 1'b0, NO_BYPASS, NO_BYPASS);
        tick();
        // x0 as source and destination
        drive_instr('0, '0, '0, OPCODE_OP, 1'b0);
        @(negedge clk);
        expect_outputs(1'b0, 1'b1, NO_BYPASS, NO_BYPASS);
        tick();
        drive_instr('0, '0, '0, OPCODE_STORE, 1'b0);
        @(negedge clk);
        expect_outputs(1'b0, 1'b1, NO_BYPASS, NO_BYPASS);
        tick();
        flush_pipes();
    endtask

    task automatic test_ex_chain();
        pick_distinct_regs();
        drive_instr(r[1], r[2], r[0], OPCODE_OP, 1'b0);
        @(negedge clk);
        expect_outputs(1'b0, 1'b1, NO_BYPASS, NO_BYPASS);
        tick();
        // Producer in ID
        drive_instr(r[0], r[3], r[4], OPCODE_OP, 1'b0);
        @(negedge clk);
        expect_outputs(1'b0, 1'b1, BY_EX_PIPE, NO_BYPASS);
        tick();
        // Producer in the EX stage
        drive_instr(r[3], r[0], r[5], OPCODE_OP, 1'b0);
        @(negedge clk);
        expect_outputs(1'b0, 1'b1, NO_BYPASS, BY_EX_ID);
        tick();
        drive_instr(r[0], r[1], r[2], OPCODE_OP, 1'b0);
        @(negedge clk);
        expect_outputs(1'b0, 1'b1, NO_BYPASS, NO_BYPASS);
        tick();
        flush_pipes();
    endtask

    task automatic test_load_use();
        int stalls;
        pick_distinct_regs();
        drive_instr(r[1], '0, r[0], OPCODE_LOAD, 1'b0);
        @(negedge clk);
        expect_outputs(1'b0, 1'b1, NO_BYPASS, NO_BYPASS);
        tick();
        drive_instr(r[2], r[0], r[3], OPCODE_OP, 1'b0);
        wait_issue(10, stalls);
        check("load-use stall cycles", 32'(stalls), 32'd2);
        expect_outputs(1'b0, 1'b1, NO_BYPASS, BY_MEM_PIPE);
        tick();
        flush_pipes();
    endtask

    task automatic test_store_fwd();
        pick_distinct_regs();
        drive_instr(r[1], '0, r[0], OPCODE_LOAD, 1'b0);
        @(negedge clk);
        expect_outputs(1'b0, 1'b1, NO_BYPASS, NO_BYPASS);
        tick();
        // Load in ID does not hold back store data
        drive_instr(r[2], r[0], '0, OPCODE_STORE, 1'b0);
        @(negedge clk);
        expect_outputs(1'b0, 1'b1, NO_BYPASS, NO_BYPASS);
        tick();
        drive_instr(r[3], r[0], '0, OPCODE_STORE, 1'b0);
        @(negedge clk);
        expect_outputs(1'b0, 1'b1, NO_BYPASS, BY_MEM_TL);
        tick();
        flush_pipes();
    endtask

    task automatic test_mul_dep();
        int stalls;
        pick_distinct_regs();
        drive_instr(r[1], r[2], r[0], OPCODE_OP, 1'b1);
        @(negedge clk);
        expect_outputs(1'b0, 1'b1, NO_BYPASS, NO_BYPASS);
        tick();
        drive_instr(r[0], r[3], r[4], OPCODE_OP, 1'b0);
        wait_issue(10, stalls);
        check("mul stall cycles", 32'(stalls), 32'd4);
        expect_outputs(1'b0, 1'b1, BY_RVM5_PIPE, NO_BYPASS);
        tick();
        flush_pipes();
    endtask

    task automatic test_waw();
        int stalls;
        pick_distinct_regs();
        drive_instr(r[1], r[2], r[0], OPCODE_OP, 1'b1);
        @(negedge clk);
        expect_outputs(1'b0, 1'b1, NO_BYPASS, NO_BYPASS);
        tick();
        // Same destination as the multiply
        drive_instr(r[3], r[4], r[0], OPCODE_OP, 1'b0);
        wait_issue(10, stalls);
        check("waw stall cycles", 32'(stalls), 32'd4);
        expect_outputs(1'b0, 1'b1, NO_BYPASS, NO_BYPASS);
        tick();
        flush_pipes();
        drive_instr(r[1], r[2], r[0], OPCODE_OP, 1'b1);
        @(negedge clk);
        expect_outputs(1'b0, 1'b1, NO_BYPASS, NO_BYPASS);
        tick();
        drive_instr(r[3], r[4], r[5], OPCODE_OP, 1'b0);
        @(negedge clk);
        expect_outputs(1'b0, 1'b1, NO_BYPASS, NO_BYPASS);
        tick();
        flush_pipes();
    endtask

    initial begin : main
        dec_valid = 1'b0;
        dec       = '0;
        void'($urandom(32'h56bba1ed));
        test_reset_idle();
        test_ex_chain();
        test_load_use();
        test_store_fwd();
        test_mul_dep();
        test_waw();
        $display("Checks: %0d  Errors: %0d  Timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Everything OK");
        end
        else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule : segre_hazard_tb

//--- verif/segre_tb_clk.sv
module segre_tb_clk (
    output logic clk_o,
    output logic arst_n_o
);

    timeunit 1ns;
    timeprecision 1ps;

    // 20 ns period
    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;
    end

    // Reset held low for five rising edges
    initial begin
        arst_n_o = 1'b0;
        repeat (5) @(posedge clk_o);
        #1 arst_n_o = 1'b1;
    end

endmodule : segre_tb_clk

//--- vlog.f
+incdir+.
design/segre_pkg.sv
design/segre_bypass_controller.sv
design/segre_wreg_tracker.sv
design/segre_issue_control.sv
design/segre_hazard_unit.sv
verif/segre_tb_clk.sv
verif/segre_hazard_tb.sv
